//--- design/tron_cfg.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// grid and start settings for the light-cycle core
// positions are 5 bits wide, so width and height must stay at or below 32
// the win count must fit the 2-bit score (1 to 3)
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef TRON_CFG_SVH
`define TRON_CFG_SVH

`define TRON_GRID_W       32
`define TRON_GRID_H       24
`define TRON_RED_X0       4
`define TRON_BLUE_X0      27
`define TRON_START_Y      12
`define TRON_WIN_CRASHES  3

`endif

//--- design/tron_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared types for the light-cycle game logic
// game_state_t leaves the values 2 and 5 to 7 unused
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package tron_pkg;

	// reverse of a heading is the value with bit 1 flipped
	typedef enum logic [1:0] {
		dir_right = 2'd0,
		dir_down  = 2'd1,
		dir_left  = 2'd2,
		dir_up    = 2'd3
	} dir_t;

	typedef enum logic [1:0] {
		cell_empty = 2'd0,
		cell_red   = 2'd1,
		cell_blue  = 2'd2
	} cell_t;

	typedef struct packed {
		logic [4:0] x;
		logic [4:0] y;
	} pos_t;

	typedef enum logic [2:0] {
		gs_idle      = 3'd0,
		gs_play      = 3'd1,
		gs_red_won   = 3'd3,
		gs_blue_won  = 3'd4
	} game_state_t;

endpackage

//--- design/step_if.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// one movement step from the mover to the trail grid
// all fields are valid only in the cycle where step is high
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

interface step_if;
	logic            step;
	tron_pkg::pos_t  red_head;
	tron_pkg::pos_t  blue_head;
	// tails are the heads before this step
	tron_pkg::pos_t  red_tail;
	tron_pkg::pos_t  blue_tail;
	logic            red_off;
	logic            blue_off;

	modport mover (output step, red_head, blue_head, red_tail, blue_tail, red_off, blue_off);
	modport grid  (input  step, red_head, blue_head, red_tail, blue_tail, red_off, blue_off);
endinterface

//--- design/cycle_mover.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// stage 1, head positions of both cycles
// a tick is taken only in play with ready high and no round restart
// a move past an edge leaves the head in place and flags it off grid
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "tron_cfg.svh"

module cycle_mover (
	input  logic                   Clk,
	input  logic                   reset,
	input  logic                   frame_tick,
	input  tron_pkg::dir_t         red_dir,
	input  tron_pkg::dir_t         blue_dir,
	input  logic                   round_restart,
	input  tron_pkg::game_state_t  game_state,
	input  logic                   ready,
	step_if.mover                  mv,
	output tron_pkg::pos_t         red_pos,
	output tron_pkg::pos_t         blue_pos
);
	localparam tron_pkg::pos_t red_start = '{x: 5'(`TRON_RED_X0), y: 5'(`TRON_START_Y)};
	localparam tron_pkg::pos_t blue_start = '{x: 5'(`TRON_BLUE_X0), y: 5'(`TRON_START_Y)};

	tron_pkg::pos_t  red_head;
	tron_pkg::pos_t  blue_head;
	tron_pkg::pos_t  red_tail;
	tron_pkg::pos_t  blue_tail;
	tron_pkg::pos_t  red_next;
	tron_pkg::pos_t  blue_next;
	tron_pkg::dir_t  red_heading;
	tron_pkg::dir_t  blue_heading;
	tron_pkg::dir_t  red_turn;
	tron_pkg::dir_t  blue_turn;
	logic            red_next_off;
	logic            blue_next_off;
	logic            red_off;
	logic            blue_off;
	logic            step_pulse;
	logic            accept;

	function automatic tron_pkg::pos_t step_pos(input tron_pkg::pos_t p,
		input tron_pkg::dir_t d, output logic off);
		tron_pkg::pos_t n;
		n = p;
		case (d)
			tron_pkg::dir_right:
			begin
				off = (p.x == 5'(`TRON_GRID_W - 1));
				n.x = off ? p.x : p.x + 5'd1;
			end
			tron_pkg::dir_down:
			begin
				off = (p.y == 5'(`TRON_GRID_H - 1));
				n.y = off ? p.y : p.y + 5'd1;
			end
			tron_pkg::dir_left:
			begin
				off = (p.x == 5'd0);
				n.x = off ? p.x : p.x - 5'd1;
			end
			default:
			begin
				off = (p.y == 5'd0);
				n.y = off ? p.y : p.y - 5'd1;
			end
		endcase
		return n;
	endfunction

	assign accept = frame_tick && ready && !round_restart && game_state == tron_pkg::gs_play;

	always_comb
	begin
		// a request for the reverse heading keeps the current one
		red_turn = ((red_dir ^ red_heading) == 2'b10) ? red_heading : red_dir;
		blue_turn = ((blue_dir ^ blue_heading) == 2'b10) ? blue_heading : blue_dir;
		red_next = step_pos(red_head, red_turn, red_next_off);
		blue_next = step_pos(blue_head, blue_turn, blue_next_off);
	end

	always_ff @(posedge Clk)
	begin
		if (reset || round_restart || game_state == tron_pkg::gs_idle)
		begin
			red_head <= red_start;
			blue_head <= blue_start;
			red_heading <= tron_pkg::dir_right;
			blue_heading <= tron_pkg::dir_left;
			step_pulse <= 1'b0;
		end
		else
		begin
			step_pulse <= accept;
			if (accept)
			begin
				red_head <= red_next;
				blue_head <= blue_next;
				red_heading <= red_turn;
				blue_heading <= blue_turn;
			end
		end
	end

	always_ff @(posedge Clk)
	begin
		if (accept)
		begin
			red_tail <= red_head;
			blue_tail <= blue_head;
			red_off <= red_next_off;
			blue_off <= blue_next_off;
		end
	end

	assign mv.step = step_pulse;
	assign mv.red_head = red_head;
	assign mv.blue_head = blue_head;
	assign mv.red_tail = red_tail;
	assign mv.blue_tail = blue_tail;
	assign mv.red_off = red_off;
	assign mv.blue_off = blue_off;

	assign red_pos = red_head;
	assign blue_pos = blue_head;
endmodule

//--- design/trail_grid.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// stage 2, trail memory with one cell_t per grid cell
// a clear sweep takes one cycle per cell after reset and round restart
// hits are valid only in the cycle where hit_valid is high
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "tron_cfg.svh"

module trail_grid (
	input  logic   Clk,
	input  logic   reset,
	step_if.grid   st,
	input  logic   round_restart,
	output logic   hit_valid,
	output logic   red_hit,
	output logic   blue_hit,
	output logic   ready
);
	localparam int cells = `TRON_GRID_W * `TRON_GRID_H;
	localparam int idx_w = $clog2(cells);

	tron_pkg::cell_t    mem [cells];
	tron_pkg::cell_t    red_cell;
	tron_pkg::cell_t    blue_cell;
	logic [idx_w-1:0]   clear_cnt;
	logic               clearing;
	logic               heads_meet;
	logic               red_crash;
	logic               blue_crash;

	function automatic logic [idx_w-1:0] cell_idx(input tron_pkg::pos_t p);
		return idx_w'(p.y) * idx_w'(`TRON_GRID_W) + idx_w'(p.x);
	endfunction

	always_comb
	begin
		red_cell = mem[cell_idx(st.red_head)];
		blue_cell = mem[cell_idx(st.blue_head)];
		heads_meet = (st.red_head == st.blue_head);
		// the other player's tail is written in this same cycle,
		// so the memory does not show it yet
		red_crash = st.red_off || heads_meet || red_cell != tron_pkg::cell_empty
			|| st.red_head == st.blue_tail;
		blue_crash = st.blue_off || heads_meet || blue_cell != tron_pkg::cell_empty
			|| st.blue_head == st.red_tail;
	end

	always_ff @(posedge Clk)
	begin
		if (clearing)
			mem[clear_cnt] <= tron_pkg::cell_empty;
		else if (st.step)
		begin
			mem[cell_idx(st.red_tail)] <= tron_pkg::cell_red;
			mem[cell_idx(st.blue_tail)] <= tron_pkg::cell_blue;
		end
	end

	// sweep counter
	always_ff @(posedge Clk)
	begin
		if (reset || round_restart)
		begin
			clearing <= 1'b1;
			clear_cnt <= '0;
		end
		else if (clearing)
		begin
			clear_cnt <= clear_cnt + 1'b1;
			if (clear_cnt == idx_w'(cells - 1))
				clearing <= 1'b0;
		end
	end

	always_ff @(posedge Clk)
	begin
		if (reset)
			hit_valid <= 1'b0;
		else
			hit_valid <= st.step;
	end

	always_ff @(posedge Clk)
	begin
		if (st.step)
		begin
			red_hit <= red_crash;
			blue_hit <= blue_crash;
		end
	end

	// low from step until scoring has had its say
	assign ready = !clearing && !st.step && !hit_valid && !round_restart;
endmodule

//--- design/round_score.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// stage 3, crash counting per player
// win flags are levels that hold until the game returns to idle
// a double hit counts one crash for each player
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "tron_cfg.svh"

module round_score (
	input  logic                   Clk,
	input  logic                   reset,
	input  tron_pkg::game_state_t  game_state,
	input  logic                   hit_valid,
	input  logic                   red_hit,
	input  logic                   blue_hit,
	output logic [1:0]             score_red,
	output logic [1:0]             score_blue,
	output logic                   red_win,
	output logic                   blue_win,
	output logic                   round_restart
);
	typedef enum logic [1:0] {
		crash_none  = 2'd0,
		crash_one   = 2'd1,
		crash_two   = 2'd2,
		crash_three = 2'd3
	} crash_t;

	localparam logic [1:0] win_count = 2'(`TRON_WIN_CRASHES);

	crash_t  red_state;
	crash_t  blue_state;
	crash_t  red_next;
	crash_t  blue_next;
	logic    any_hit;

	// count three is terminal until idle clears it
	function automatic crash_t next_crash(input crash_t cur, input logic hit);
		crash_t n;
		n = cur;
		if (hit)
		begin
			case (cur)
				crash_none: n = crash_one;
				crash_one:  n = crash_two;
				crash_two:  n = crash_three;
				default:    n = crash_three;
			endcase
		end
		return n;
	endfunction

	assign any_hit = hit_valid && (red_hit || blue_hit);

	always_comb
	begin
		red_next = next_crash(red_state, hit_valid && red_hit);
		blue_next = next_crash(blue_state, hit_valid && blue_hit);
	end

	always_ff @(posedge Clk)
	begin
		if (reset || game_state == tron_pkg::gs_idle)
		begin
			red_state <= crash_none;
			blue_state <= crash_none;
			red_win <= 1'b0;
			blue_win <= 1'b0;
			round_restart <= 1'b0;
		end
		else if (game_state == tron_pkg::gs_play)
		begin
			red_state <= red_next;
			blue_state <= blue_next;
			// a player's last crash is the opponent's win
			red_win <= red_win || blue_next == win_count;
			blue_win <= blue_win || red_next == win_count;
			round_restart <= any_hit;
		end
		else
			round_restart <= 1'b0;
	end

	assign score_red = red_state;
	assign score_blue = blue_state;
endmodule

//--- design/game_sequencer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// game state machine, idle, play and the two win states
// red wins if both win flags rise together
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module game_sequencer (
	input  logic                   Clk,
	input  logic                   reset,
	input  logic                   start,
	input  logic                   red_win,
	input  logic                   blue_win,
	output tron_pkg::game_state_t  game_state
);
	tron_pkg::game_state_t  state;
	tron_pkg::game_state_t  next_state;

	always_comb
	begin
		next_state = state;
		case (state)
			tron_pkg::gs_idle:
				if (start)
					next_state = tron_pkg::gs_play;
			tron_pkg::gs_play:
				if (red_win)
					next_state = tron_pkg::gs_red_won;
				else if (blue_win)
					next_state = tron_pkg::gs_blue_won;
			tron_pkg::gs_red_won, tron_pkg::gs_blue_won:
				if (start)
					next_state = tron_pkg::gs_idle;
			default:
				next_state = tron_pkg::gs_idle;
		endcase
	end

	always_ff @(posedge Clk)
	begin
		if (reset)
			state <= tron_pkg::gs_idle;
		else
			state <= next_state;
	end

	assign game_state = state;
endmodule

//--- design/tron_core.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// game logic top, mover, trail grid, scoring and game sequencer
// frame_tick is a one-cycle strobe in the Clk domain
// scores change 3 cycles after an accepted tick
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module tron_core (
	input  logic                   Clk,
	input  logic                   reset,
	input  logic                   start,
	input  logic                   frame_tick,
	input  tron_pkg::dir_t         red_dir,
	input  tron_pkg::dir_t         blue_dir,
	output logic [4:0]             red_x,
	output logic [4:0]             red_y,
	output logic [4:0]             blue_x,
	output logic [4:0]             blue_y,
	output logic [1:0]             score_red,
	output logic [1:0]             score_blue,
	output logic                   red_win,
	output logic                   blue_win,
	output logic                   round_reset,
	output tron_pkg::game_state_t  game_state,
	output logic                   ready
);
	tron_pkg::pos_t  red_pos;
	tron_pkg::pos_t  blue_pos;
	logic            hit_valid;
	logic            red_hit;
	logic            blue_hit;
	logic            round_restart;

	step_if step_bus ();

	cycle_mover cycle_mover_inst (
		.Clk           (Clk),
		.reset         (reset),
		.frame_tick    (frame_tick),
		.red_dir       (red_dir),
		.blue_dir      (blue_dir),
		.round_restart (round_restart),
		.game_state    (game_state),
		.ready         (ready),
		.mv            (step_bus),
		.red_pos       (red_pos),
		.blue_pos      (blue_pos)
	);

	trail_grid trail_grid_inst (
		.Clk           (Clk),
		.reset         (reset),
		.st            (step_bus),
		.round_restart (round_restart),
		.hit_valid     (hit_valid),
		.red_hit       (red_hit),
		.blue_hit      (blue_hit),
		.ready         (ready)
	);

	round_score round_score_inst (
		.Clk           (Clk),
		.reset         (reset),
		.game_state    (game_state),
		.hit_valid     (hit_valid),
		.red_hit       (red_hit),
		.blue_hit      (blue_hit),
		.score_red     (score_red),
		.score_blue    (score_blue),
		.red_win       (red_win),
		.blue_win      (blue_win),
		.round_restart (round_restart)
	);

	game_sequencer game_sequencer_inst (
		.Clk        (Clk),
		.reset      (reset),
		.start      (start),
		.red_win    (red_win),
		.blue_win   (blue_win),
		.game_state (game_state)
	);

	assign round_reset = round_restart;
	assign red_x = red_pos.x;
	assign red_y = red_pos.y;
	assign blue_x = blue_pos.x;
	assign blue_y = blue_pos.y;
endmodule

//--- dv/tron_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// replays dv/tron_stim.txt from the project root against tron_core
// each line is applied once ready is high and checked 8 cycles later
// start and frame_tick are one-cycle pulses and directions hold until the next line
// a line whose expected score rises must show exactly one round_reset pulse
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module tron_tb;
	localparam int ready_limit = 2000;
	localparam int settle_cycles = 8;

	logic                   Clk = 1'b0;
	logic                   reset;
	logic                   start;
	logic                   frame_tick;
	tron_pkg::dir_t         red_dir;
	tron_pkg::dir_t         blue_dir;
	logic [4:0]             red_x;
	logic [4:0]             red_y;
	logic [4:0]             blue_x;
	logic [4:0]             blue_y;
	logic [1:0]             score_red;
	logic [1:0]             score_blue;
	logic                   red_win;
	logic                   blue_win;
	logic                   round_reset;
	tron_pkg::game_state_t  game_state;
	logic                   ready;

	// fields of one stimulus line
	int s_start;
	int s_red_dir;
	int s_blue_dir;
	int s_tick;
	int e_red_x;
	int e_red_y;
	int e_blue_x;
	int e_blue_y;
	int e_score_red;
	int e_score_blue;
	int e_red_win;
	int e_blue_win;
	int e_round_reset;
	int e_state;
	int e_ready;

	// expected scores of the line before
	int prev_score_red;
	int prev_score_blue;
	int restart_pulses;

	int     fd;
	int     fields;
	int     lines_done;
	string  line;

	tron_core tron_core_inst (
		.Clk         (Clk),
		.reset       (reset),
		.start       (start),
		.frame_tick  (frame_tick),
		.red_dir     (red_dir),
		.blue_dir    (blue_dir),
		.red_x       (red_x),
		.red_y       (red_y),
		.blue_x      (blue_x),
		.blue_y      (blue_y),
		.score_red   (score_red),
		.score_blue  (score_blue),
		.red_win     (red_win),
		.blue_win    (blue_win),
		.round_reset (round_reset),
		.game_state  (game_state),
		.ready       (ready)
	);

	always #4 Clk = ~Clk;

	task automatic check_value(input string name, input int actual, input int expected);
		if (actual != expected)
		begin
			$display("[FAIL] %0t: %s is %0d, expected %0d on stimulus line %0d",
				$time, name, actual, expected, lines_done + 1);
			$display("sim failed");
			$fatal(1, "output mismatch");
		end
	endtask

	// called on a falling edge
	task automatic wait_ready();
		int waited;
		waited = 0;
		while (!ready)
		begin
			@(negedge Clk);
			waited++;
			if (waited >= ready_limit)
			begin
				$display("ready never returned high within %0d cycles, time %0t",
					ready_limit, $time);
				$display("sim failed");
				$fatal(1, "ready timeout");
			end
		end
	endtask

	// counts the falling edges that see round_reset high
	task automatic apply_line(output int pulses);
		pulses = 0;
		start = s_start[0];
		frame_tick = s_tick[0];
		red_dir = tron_pkg::dir_t'(s_red_dir[1:0]);
		blue_dir = tron_pkg::dir_t'(s_blue_dir[1:0]);
		@(negedge Clk);
		start = 1'b0;
		frame_tick = 1'b0;
		pulses += int'(round_reset);
		repeat (settle_cycles - 1)
		begin
			@(negedge Clk);
			pulses += int'(round_reset);
		end
	endtask

	task automatic check_outputs();
		check_value("red_x", int'(red_x), e_red_x);
		check_value("red_y", int'(red_y), e_red_y);
		check_value("blue_x", int'(blue_x), e_blue_x);
		check_value("blue_y", int'(blue_y), e_blue_y);
		check_value("score_red", int'(score_red), e_score_red);
		check_value("score_blue", int'(score_blue), e_score_blue);
		check_value("red_win", int'(red_win), e_red_win);
		check_value("blue_win", int'(blue_win), e_blue_win);
		check_value("round_reset", int'(round_reset), e_round_reset);
		// any crash restarts the round once, a double hit included
		check_value("round_reset pulses", restart_pulses,
			(e_score_red > prev_score_red || e_score_blue > prev_score_blue) ? 1 : 0);
		check_value("game_state", int'(game_state), e_state);
		check_value("ready", int'(ready), e_ready);
	endtask

	initial
	begin
		reset = 1'b1;
		start = 1'b0;
		frame_tick = 1'b0;
		red_dir = tron_pkg::dir_right;
		blue_dir = tron_pkg::dir_left;
		lines_done = 0;
		prev_score_red = 0;
		prev_score_blue = 0;
		restart_pulses = 0;

		fd = $fopen("dv/tron_stim.txt", "r");
		if (fd == 0)
		begin
			$display("could not open the stimulus file dv/tron_stim.txt");
			$display("sim failed");
			$fatal(1, "no stimulus");
		end

		repeat (10) @(negedge Clk);
		reset = 1'b0;

		// comment and blank lines scan as zero fields
		while ($fgets(line, fd) > 0)
		begin
			fields = $sscanf(line, "%d %d %d %d %d %d %d %d %d %d %d %d %d %d %d",
				s_start, s_red_dir, s_blue_dir, s_tick,
				e_red_x, e_red_y, e_blue_x, e_blue_y,
				e_score_red, e_score_blue, e_red_win, e_blue_win,
				e_round_reset, e_state, e_ready);
			if (fields == 15)
			begin
				wait_ready();
				apply_line(restart_pulses);
				check_outputs();
				prev_score_red = e_score_red;
				prev_score_blue = e_score_blue;
				lines_done++;
			end
			else if (fields > 0)
			begin
				$display("stimulus line %0d has %0d fields instead of 15", lines_done + 1, fields);
				$display("sim failed");
				$fatal(1, "bad stimulus");
			end
		end
		$fclose(fd);

		if (lines_done == 0)
		begin
			$display("the stimulus file holds no data lines");
			$display("sim failed");
			$fatal(1, "empty stimulus");
		end
		else
		begin
			$display("checked %0d stimulus lines", lines_done);
			$display("sim passed");
			$finish;
		end
	end
endmodule

//--- dv/tron_stim.txt
# start red_dir blue_dir tick | expected red_x red_y blue_x blue_y score_red score_blue
# red_win blue_win round_reset game_state ready | dir 0 right 1 down 2 left 3 up
# idle after reset, then start
0 0 2 0 4 12 27 12 0 0 0 0 0 0 1
1 0 2 0 4 12 27 12 0 0 0 0 0 1 1
# round 1, blue turns up then left, reverse requests ignored, red runs into blue's trail
0 0 3 1 5 12 27 11 0 0 0 0 0 1 1
0 2 2 1 6 12 26 11 0 0 0 0 0 1 1
0 0 0 1 7 12 25 11 0 0 0 0 0 1 1
0 0 2 1 8 12 24 11 0 0 0 0 0 1 1
0 0 2 1 9 12 23 11 0 0 0 0 0 1 1
0 0 2 1 10 12 22 11 0 0 0 0 0 1 1
0 0 2 1 11 12 21 11 0 0 0 0 0 1 1
0 0 2 1 12 12 20 11 0 0 0 0 0 1 1
0 0 2 1 13 12 19 11 0 0 0 0 0 1 1
0 0 2 1 14 12 18 11 0 0 0 0 0 1 1
0 0 2 1 15 12 17 11 0 0 0 0 0 1 1
0 0 2 1 16 12 16 11 0 0 0 0 0 1 1
0 3 2 1 4 12 27 12 1 0 0 0 0 1 0
# round 2, red drives off the left edge
0 3 2 1 4 11 26 12 1 0 0 0 0 1 1
0 2 2 1 3 11 25 12 1 0 0 0 0 1 1
0 2 2 1 2 11 24 12 1 0 0 0 0 1 1
0 2 2 1 1 11 23 12 1 0 0 0 0 1 1
0 2 2 1 0 11 22 12 1 0 0 0 0 1 1
0 2 2 1 4 12 27 12 2 0 0 0 0 1 0
# round 3, head-on on row 12, third red crash wins for blue
0 0 2 1 5 12 26 12 2 0 0 0 0 1 1
0 0 2 1 6 12 25 12 2 0 0 0 0 1 1
0 0 2 1 7 12 24 12 2 0 0 0 0 1 1
0 0 2 1 8 12 23 12 2 0 0 0 0 1 1
0 0 2 1 9 12 22 12 2 0 0 0 0 1 1
0 0 2 1 10 12 21 12 2 0 0 0 0 1 1
0 0 2 1 11 12 20 12 2 0 0 0 0 1 1
0 0 2 1 12 12 19 12 2 0 0 0 0 1 1
0 0 2 1 13 12 18 12 2 0 0 0 0 1 1
0 0 2 1 14 12 17 12 2 0 0 0 0 1 1
0 0 2 1 15 12 16 12 2 0 0 0 0 1 1
0 0 2 1 4 12 27 12 3 1 0 1 0 4 0
# tick in the win state moves nothing, start goes to idle, then a new game
0 0 2 1 4 12 27 12 3 1 0 1 0 4 1
1 0 2 0 4 12 27 12 0 0 0 0 0 0 1
1 0 2 0 4 12 27 12 0 0 0 0 0 1 1
0 0 2 1 5 12 26 12 0 0 0 0 0 1 1

//--- project.f
+incdir+design
design/tron_pkg.sv
design/step_if.sv
design/cycle_mover.sv
design/trail_grid.sv
design/round_score.sv
design/game_sequencer.sv
design/tron_core.sv
dv/tron_tb.sv

//--- run_sim.sh
#!/bin/sh
# builds the light-cycle testbench with Verilator and runs it
# the verdict comes from sim.log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f project.f --top-module tron_tb -Mdir obj_dir -o tron_sim
if [ $? -ne 0 ]; then
	echo "RESULT: FAIL (build error)"
	exit 1
fi

./obj_dir/tron_sim > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q "sim failed" sim.log; then
	echo "RESULT: FAIL"
	exit 1
fi
if [ $run_status -ne 0 ] || ! grep -q "sim passed" sim.log; then
	echo "RESULT: FAIL (simulator status $run_status)"
	exit 1
fi
echo "RESULT: PASS"
exit 0
